/* hw/cpu_pkg.sv */
// shared datapath types for the pipeline back end
// ALU function codes, ALU control codes, writeback source codes
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;     // datapath word
	typedef logic [4:0]  reg_addr_t; // register number
	typedef logic [5:0]  func_t;     // ALU function or control code
	typedef logic [4:0]  shamt_t;    // shift amount
	typedef logic [25:0] jidx_t;     // jump index field
	typedef logic [1:0]  wb_src_t;   // writeback source
	typedef logic [1:0]  drw_t;      // bit 0 store, bit 1 load

	// **************************************************
	// ALU function codes
	localparam func_t FN_SLL   = 6'h00;
	localparam func_t FN_SLLV  = 6'h01;
	localparam func_t FN_SRL   = 6'h02;
	localparam func_t FN_SRLV  = 6'h03;
	localparam func_t FN_NE    = 6'h04;
	localparam func_t FN_EQ    = 6'h05;
	localparam func_t FN_MULLO = 6'h10;
	localparam func_t FN_MULHI = 6'h11;
	localparam func_t FN_ADD   = 6'h21;
	localparam func_t FN_SUB   = 6'h23;
	localparam func_t FN_AND   = 6'h24;
	localparam func_t FN_OR    = 6'h25;
	localparam func_t FN_NOR   = 6'h27;
	localparam func_t FN_SLT   = 6'h2a;
	localparam func_t FN_SLTU  = 6'h2b;

	// **************************************************
	// ALU control codes, taken from the opcode
	localparam func_t AC_RTYPE = 6'h00; // use the function field
	localparam func_t AC_BEQ   = 6'h04;
	localparam func_t AC_BNE   = 6'h05;
	localparam func_t AC_ADDI  = 6'h08;
	localparam func_t AC_ADDIU = 6'h09;
	localparam func_t AC_SLTI  = 6'h0a;
	localparam func_t AC_SLTIU = 6'h0b;
	localparam func_t AC_ANDI  = 6'h0c;
	localparam func_t AC_ORI   = 6'h0d;
	localparam func_t AC_LUI   = 6'h0f;
	localparam func_t AC_LW    = 6'h23;
	localparam func_t AC_SW    = 6'h2b;

	localparam wb_src_t WB_ALU  = 2'd0;
	localparam wb_src_t WB_MEM  = 2'd1;
	localparam wb_src_t WB_LINK = 2'd2; // return address of jal

endpackage

`default_nettype wire

/* hw/ex_mem_if.sv */
// execute to memory pipeline register bundle
// modports for the execute stage and the memory stage
`default_nettype none

interface ex_mem_if;

	logic               rfw;      // register file write enable
	cpu_pkg::wb_src_t   wbsource;
	cpu_pkg::drw_t      drw;
	cpu_pkg::word_t     alu_r;    // ALU result, also the memory address
	cpu_pkg::word_t     rfb;      // store data
	cpu_pkg::reg_addr_t rf_waddr;
	cpu_pkg::word_t     jalra;    // link value
	cpu_pkg::reg_addr_t rt;

	modport ex (output rfw, wbsource, drw, alu_r, rfb, rf_waddr, jalra, rt);
	modport mem (input rfw, wbsource, drw, alu_r, rfb, rf_waddr, jalra, rt);

endinterface

`default_nettype wire

/* hw/cpu_rf.sv */
// 32 entry register file, two asynchronous read ports, one write port
`default_nettype none

module cpu_rf (
	input  wire logic               clk,
	input  wire logic               arst_n,
	input  wire logic               stall,
	input  wire cpu_pkg::reg_addr_t rs,
	input  wire cpu_pkg::reg_addr_t rt,
	output cpu_pkg::word_t          rdata_a,
	output cpu_pkg::word_t          rdata_b,
	input  wire logic               we,
	input  wire cpu_pkg::reg_addr_t waddr,
	input  wire cpu_pkg::word_t     wdata
);

	cpu_pkg::word_t regs [32];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && !stall && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// r0 is hardwired
	assign rdata_a = (rs == '0) ? '0 : regs[rs];
	assign rdata_b = (rt == '0) ? '0 : regs[rt];

endmodule

`default_nettype wire

/* hw/cpu_alu.sv */
// ALU control decode from opcode class to function code
// ALU datapath with add, logic, compares, shifts and 64 bit signed multiply
`default_nettype none

module cpu_alu (
	input  wire cpu_pkg::func_t  alucontrol,
	input  wire cpu_pkg::func_t  func,
	input  wire cpu_pkg::shamt_t shamt,
	input  wire cpu_pkg::word_t  x,
	input  wire cpu_pkg::word_t  y,
	output cpu_pkg::word_t       result
);

	cpu_pkg::func_t  alu_func;
	logic            func_valid; // low for unknown control codes
	cpu_pkg::shamt_t sh;
	logic [63:0]     mul_r;
	logic            lt_s;
	logic            lt_u;

	// **************************************************
	// control decode
	always_comb begin
		func_valid = 1'b1;
		case (alucontrol)
			cpu_pkg::AC_RTYPE: alu_func = func;
			cpu_pkg::AC_ADDI,
			cpu_pkg::AC_ADDIU,
			cpu_pkg::AC_LW,
			cpu_pkg::AC_SW:    alu_func = cpu_pkg::FN_ADD; // address calc for lw/sw
			cpu_pkg::AC_ANDI:  alu_func = cpu_pkg::FN_AND;
			cpu_pkg::AC_ORI:   alu_func = cpu_pkg::FN_OR;
			cpu_pkg::AC_SLTI:  alu_func = cpu_pkg::FN_SLT;
			cpu_pkg::AC_SLTIU: alu_func = cpu_pkg::FN_SLTU;
			cpu_pkg::AC_LUI:   alu_func = cpu_pkg::FN_SLL;
			cpu_pkg::AC_BEQ:   alu_func = cpu_pkg::FN_NE; // zero result means taken
			cpu_pkg::AC_BNE:   alu_func = cpu_pkg::FN_EQ;
			default: begin
				alu_func   = cpu_pkg::FN_SLL;
				func_valid = 1'b0;
			end
		endcase
	end

	assign sh = (alucontrol == cpu_pkg::AC_LUI) ? 5'd16 : shamt; // lui shifts the imm up

	// **************************************************
	// datapath
	assign mul_r = 64'($signed(x) * $signed(y));
	assign lt_s  = $signed(x) < $signed(y);
	assign lt_u  = x < y;

	always_comb begin
		result = '0;
		if (func_valid) begin
			case (alu_func)
				cpu_pkg::FN_ADD:   result = x + y;
				cpu_pkg::FN_SUB:   result = x - y;
				cpu_pkg::FN_AND:   result = x & y;
				cpu_pkg::FN_OR:    result = x | y;
				cpu_pkg::FN_NOR:   result = ~(x | y);
				cpu_pkg::FN_SLT:   result = {31'b0, lt_s};
				cpu_pkg::FN_SLTU:  result = {31'b0, lt_u};
				cpu_pkg::FN_SLL:   result = y << sh;
				cpu_pkg::FN_SRL:   result = y >> sh;
				cpu_pkg::FN_SLLV:  result = x << y; // full word shift count
				cpu_pkg::FN_SRLV:  result = x >> y;
				cpu_pkg::FN_NE:    result = {31'b0, x != y};
				cpu_pkg::FN_EQ:    result = {31'b0, x == y};
				cpu_pkg::FN_MULLO: result = mul_r[31:0];
				cpu_pkg::FN_MULHI: result = mul_r[63:32];
				default:           result = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/cpu_ex.sv */
// execute stage with operand forwarding and operand select
// branch and jump target generation, link address
// execute pipeline register feeding the memory stage
`default_nettype none

module cpu_ex (
	input  wire logic               clk,
	input  wire logic               arst_n,
	input  wire logic               stall,
	input  wire logic               flush,
	input  wire logic               id_c_rfw,
	input  wire cpu_pkg::wb_src_t   id_c_wbsource,
	input  wire cpu_pkg::drw_t      id_c_drw,
	input  wire cpu_pkg::func_t     id_c_alucontrol,
	input  wire logic               id_c_j,
	input  wire logic               id_c_b,
	input  wire logic               id_c_jjr,
	input  wire logic               id_c_rfbse,
	input  wire cpu_pkg::word_t     id_rfa,
	input  wire cpu_pkg::word_t     id_rfb,
	input  wire cpu_pkg::word_t     id_se,
	input  wire cpu_pkg::shamt_t    id_shamt,
	input  wire cpu_pkg::func_t     id_func,
	input  wire cpu_pkg::word_t     id_pc,
	input  wire cpu_pkg::jidx_t     id_jaddr,
	input  wire cpu_pkg::reg_addr_t id_rs,
	input  wire cpu_pkg::reg_addr_t id_rt,
	input  wire cpu_pkg::reg_addr_t id_rf_waddr,
	input  wire cpu_pkg::word_t     wb_wdata,
	input  wire logic               wb_rfw,
	input  wire cpu_pkg::reg_addr_t wb_waddr,
	ex_mem_if.ex                    ex_mem,
	output cpu_pkg::word_t          baddr,
	output cpu_pkg::word_t          jaddr,
	output logic                    c_b,
	output logic                    c_j
);

	logic           fwd1_x, fwd2_x;
	logic           fwd1_y, fwd2_y;
	cpu_pkg::word_t x;
	cpu_pkg::word_t y_fwd;      // forwarded rt value, used as store data
	cpu_pkg::word_t y;
	cpu_pkg::word_t alu_r;
	cpu_pkg::word_t pc_4;
	cpu_pkg::word_t jalra;

	// **************************************************
	// forwarding, distance 1 wins over distance 2
	assign fwd1_x = ex_mem.rfw && (ex_mem.rf_waddr != '0) && (ex_mem.rf_waddr == id_rs);
	assign fwd2_x = wb_rfw && (wb_waddr != '0) && (wb_waddr == id_rs);
	assign fwd1_y = ex_mem.rfw && (ex_mem.rf_waddr != '0) && (ex_mem.rf_waddr == id_rt);
	assign fwd2_y = wb_rfw && (wb_waddr != '0) && (wb_waddr == id_rt);

	assign x     = fwd1_x ? ex_mem.alu_r : (fwd2_x ? wb_wdata : id_rfa);
	assign y_fwd = fwd1_y ? ex_mem.alu_r : (fwd2_y ? wb_wdata : id_rfb);
	assign y     = id_c_rfbse ? id_se : y_fwd; // immediate ops

	cpu_alu u_cpu_alu (
		.alucontrol (id_c_alucontrol),
		.func       (id_func),
		.shamt      (id_shamt),
		.x          (x),
		.y          (y),
		.result     (alu_r)
	);

	// **************************************************
	// branch and jump
	assign pc_4  = id_pc + 32'd4;
	assign jalra = id_pc + 32'd8;
	assign baddr = pc_4 + {id_se[29:0], 2'b00};
	assign jaddr = id_c_jjr ? x : {pc_4[31:28], id_jaddr, 2'b00};
	assign c_b   = id_c_b && (alu_r == '0);
	assign c_j   = id_c_j;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem.rfw      <= 1'b0;
			ex_mem.wbsource <= cpu_pkg::WB_ALU;
			ex_mem.drw      <= '0;
			ex_mem.alu_r    <= '0;
			ex_mem.rfb      <= '0;
			ex_mem.rf_waddr <= '0;
			ex_mem.jalra    <= '0;
			ex_mem.rt       <= '0;
		end else if (!stall) begin
			if (flush) begin // bubble
				ex_mem.rfw      <= 1'b0;
				ex_mem.wbsource <= cpu_pkg::WB_ALU;
				ex_mem.drw      <= '0;
				ex_mem.alu_r    <= '0;
				ex_mem.rfb      <= '0;
				ex_mem.rf_waddr <= '0;
				ex_mem.jalra    <= '0;
				ex_mem.rt       <= '0;
			end else begin
				ex_mem.rfw      <= id_c_rfw;
				ex_mem.wbsource <= id_c_wbsource;
				ex_mem.drw      <= id_c_drw;
				ex_mem.alu_r    <= alu_r;
				ex_mem.rfb      <= y_fwd;
				ex_mem.rf_waddr <= id_rf_waddr;
				ex_mem.jalra    <= jalra;
				ex_mem.rt       <= id_rt;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/cpu_mem.sv */
// memory stage with word addressed data memory
// memory/writeback register and writeback data select
`default_nettype none

module cpu_mem #(
	parameter int DMEM_WORDS = 256
) (
	input  wire logic         clk,
	input  wire logic         arst_n,
	input  wire logic         stall,
	ex_mem_if.mem             ex_mem,
	output logic              wb_rfw,
	output cpu_pkg::reg_addr_t wb_waddr,
	output cpu_pkg::word_t    wb_wdata
);

	localparam int AW = $clog2(DMEM_WORDS);

	cpu_pkg::word_t   dmem [DMEM_WORDS];
	logic [AW-1:0]    dmem_addr;
	cpu_pkg::word_t   dmem_rdata;
	cpu_pkg::word_t   st_data;
	logic             st_fwd;
	cpu_pkg::wb_src_t wb_src_r;
	cpu_pkg::word_t   wb_alu_r;
	cpu_pkg::word_t   wb_mem_r;
	cpu_pkg::word_t   wb_jalra_r;

	assign dmem_addr  = ex_mem.alu_r[AW+1:2]; // byte address to word index
	assign dmem_rdata = dmem[dmem_addr];

	// load result in writeback feeding a store's data register
	assign st_fwd  = wb_rfw && (wb_src_r == cpu_pkg::WB_MEM) &&
		(ex_mem.rt != '0) && (wb_waddr == ex_mem.rt);
	assign st_data = st_fwd ? wb_mem_r : ex_mem.rfb;

	always_ff @(posedge clk) begin
		if (ex_mem.drw[0] && !stall) begin
			dmem[dmem_addr] <= st_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb_rfw     <= 1'b0;
			wb_waddr   <= '0;
			wb_src_r   <= cpu_pkg::WB_ALU;
			wb_alu_r   <= '0;
			wb_mem_r   <= '0;
			wb_jalra_r <= '0;
		end else if (!stall) begin
			wb_rfw     <= ex_mem.rfw;
			wb_waddr   <= ex_mem.rf_waddr;
			wb_src_r   <= ex_mem.wbsource;
			wb_alu_r   <= ex_mem.alu_r;
			wb_mem_r   <= ex_mem.drw[1] ? dmem_rdata : '0; // only loads capture
			wb_jalra_r <= ex_mem.jalra;
		end
	end

	always_comb begin
		case (wb_src_r)
			cpu_pkg::WB_MEM:  wb_wdata = wb_mem_r;
			cpu_pkg::WB_LINK: wb_wdata = wb_jalra_r;
			default:          wb_wdata = wb_alu_r;
		endcase
	end

endmodule

`default_nettype wire

/* hw/cpu_backend.sv */
// top level of the pipeline back end
// register file, execute stage and memory stage
`default_nettype none

module cpu_backend #(
	parameter int DMEM_WORDS = 256
) (
	input  wire logic               clk,
	input  wire logic               arst_n,
	input  wire logic               stall,
	input  wire logic               flush,
	input  wire logic               id_c_rfw,
	input  wire cpu_pkg::wb_src_t   id_c_wbsource,
	input  wire cpu_pkg::drw_t      id_c_drw,
	input  wire cpu_pkg::func_t     id_c_alucontrol,
	input  wire logic               id_c_j,
	input  wire logic               id_c_b,
	input  wire logic               id_c_jjr,
	input  wire logic               id_c_rfbse,
	input  wire cpu_pkg::word_t     id_se,
	input  wire cpu_pkg::shamt_t    id_shamt,
	input  wire cpu_pkg::func_t     id_func,
	input  wire cpu_pkg::word_t     id_pc,
	input  wire cpu_pkg::jidx_t     id_jaddr,
	input  wire cpu_pkg::reg_addr_t id_rs,
	input  wire cpu_pkg::reg_addr_t id_rt,
	input  wire cpu_pkg::reg_addr_t id_rf_waddr,
	output cpu_pkg::word_t          baddr,
	output cpu_pkg::word_t          jaddr,
	output logic                    c_b,
	output logic                    c_j,
	output logic                    wb_rfw,
	output cpu_pkg::reg_addr_t      wb_waddr,
	output cpu_pkg::word_t          wb_wdata
);

	cpu_pkg::word_t rf_a;
	cpu_pkg::word_t rf_b;

	ex_mem_if ex_mem ();

	cpu_rf u_cpu_rf (
		.clk     (clk),
		.arst_n  (arst_n),
		.stall   (stall),
		.rs      (id_rs),
		.rt      (id_rt),
		.rdata_a (rf_a),
		.rdata_b (rf_b),
		.we      (wb_rfw),
		.waddr   (wb_waddr),
		.wdata   (wb_wdata)
	);

	cpu_ex u_cpu_ex (
		.clk             (clk),
		.arst_n          (arst_n),
		.stall           (stall),
		.flush           (flush),
		.id_c_rfw        (id_c_rfw),
		.id_c_wbsource   (id_c_wbsource),
		.id_c_drw        (id_c_drw),
		.id_c_alucontrol (id_c_alucontrol),
		.id_c_j          (id_c_j),
		.id_c_b          (id_c_b),
		.id_c_jjr        (id_c_jjr),
		.id_c_rfbse      (id_c_rfbse),
		.id_rfa          (rf_a),
		.id_rfb          (rf_b),
		.id_se           (id_se),
		.id_shamt        (id_shamt),
		.id_func         (id_func),
		.id_pc           (id_pc),
		.id_jaddr        (id_jaddr),
		.id_rs           (id_rs),
		.id_rt           (id_rt),
		.id_rf_waddr     (id_rf_waddr),
		.wb_wdata        (wb_wdata),
		.wb_rfw          (wb_rfw),
		.wb_waddr        (wb_waddr),
		.ex_mem          (ex_mem.ex),
		.baddr           (baddr),
		.jaddr           (jaddr),
		.c_b             (c_b),
		.c_j             (c_j)
	);

	cpu_mem #(
		.DMEM_WORDS (DMEM_WORDS)
	) u_cpu_mem (
		.clk      (clk),
		.arst_n   (arst_n),
		.stall    (stall),
		.ex_mem   (ex_mem.mem),
		.wb_rfw   (wb_rfw),
		.wb_waddr (wb_waddr),
		.wb_wdata (wb_wdata)
	);

endmodule

`default_nettype wire

/* bench/cpu_backend_props.sv */
// execute register assertions, bound into the execute stage
`default_nettype none

module cpu_backend_props (
	input wire logic               clk,
	input wire logic               arst_n,
	input wire logic               stall,
	input wire logic               flush,
	input wire logic               id_c_rfw,
	input wire logic               rfw,
	input wire cpu_pkg::wb_src_t   wbsource,
	input wire cpu_pkg::drw_t      drw,
	input wire cpu_pkg::word_t     alu_r,
	input wire cpu_pkg::word_t     rfb,
	input wire cpu_pkg::reg_addr_t rf_waddr,
	input wire cpu_pkg::word_t     jalra,
	input wire cpu_pkg::reg_addr_t rt
);
	timeunit 1ns;
	timeprecision 100ps;

	// rfw only rises when a writing instruction was accepted
	a_rfw_source: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(rfw) |-> $past(id_c_rfw && !flush && !stall))
		else $error("execute rfw rose without a writing instruction");

	a_flush_bubble: assert property (@(posedge clk) disable iff (!arst_n)
		(flush && !stall) |=> !rfw)
		else $error("flush did not clear execute rfw");

	a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
		stall |=> ($stable(rfw) && $stable(wbsource) && $stable(drw) &&
			$stable(alu_r) && $stable(rfb) && $stable(rf_waddr) &&
			$stable(jalra) && $stable(rt)))
		else $error("execute register changed during stall");

endmodule

bind cpu_ex cpu_backend_props u_cpu_backend_props (
	.clk      (clk),
	.arst_n   (arst_n),
	.stall    (stall),
	.flush    (flush),
	.id_c_rfw (id_c_rfw),
	.rfw      (ex_mem.rfw),
	.wbsource (ex_mem.wbsource),
	.drw      (ex_mem.drw),
	.alu_r    (ex_mem.alu_r),
	.rfb      (ex_mem.rfb),
	.rf_waddr (ex_mem.rf_waddr),
	.jalra    (ex_mem.jalra),
	.rt       (ex_mem.rt)
);

`default_nettype wire

/* bench/tb_cpu_backend.sv */
// directed tests for the pipeline back end
// shadow register and memory model, writeback queue checker
`default_nettype none

module tb_cpu_backend;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	logic               clk, arst_n, stall, flush;
	logic               id_c_rfw, id_c_j, id_c_b, id_c_jjr, id_c_rfbse;
	cpu_pkg::wb_src_t   id_c_wbsource;
	cpu_pkg::drw_t      id_c_drw;
	cpu_pkg::func_t     id_c_alucontrol, id_func;
	cpu_pkg::word_t     id_se, id_pc;
	cpu_pkg::shamt_t    id_shamt;
	cpu_pkg::jidx_t     id_jaddr;
	cpu_pkg::reg_addr_t id_rs, id_rt, id_rf_waddr;
	cpu_pkg::word_t     baddr, jaddr, wb_wdata;
	logic               c_b, c_j, wb_rfw;
	cpu_pkg::reg_addr_t wb_waddr;

	cpu_pkg::reg_addr_t q_addr[$]; // pending writebacks
	cpu_pkg::word_t     q_data[$];
	int                 q_cyc[$];  // expected commit edge
	cpu_pkg::word_t     shadow[32];
	cpu_pkg::word_t     mem_m[256];
	cpu_pkg::word_t     pc;
	logic [31:0]        lfsr;
	int                 cyc, errors, checks;

	cpu_backend #(.DMEM_WORDS(256)) u_cpu_backend (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic cpu_pkg::word_t rnd(int n);
		cpu_pkg::word_t r;
		logic           b;
		r = '0;
		for (int i = 0; i < n; i++) begin
			b    = lfsr[0];
			lfsr = lfsr >> 1;
			if (b) lfsr = lfsr ^ LFSR_TAPS;
			r = {r[30:0], b};
		end
		return r;
	endfunction

	function automatic cpu_pkg::word_t sext16(cpu_pkg::word_t v);
		return {{16{v[15]}}, v[15:0]};
	endfunction

	// **************************************************
	// reference ALU
	function automatic cpu_pkg::word_t exp_alu(cpu_pkg::func_t ac, cpu_pkg::func_t fn,
			cpu_pkg::shamt_t sh, cpu_pkg::word_t x, cpu_pkg::word_t y);
		cpu_pkg::func_t f;
		logic [63:0]    p;
		p = $signed({{32{x[31]}}, x}) * $signed({{32{y[31]}}, y});
		case (ac)
			cpu_pkg::AC_RTYPE: f = fn;
			cpu_pkg::AC_ADDI, cpu_pkg::AC_ADDIU,
			cpu_pkg::AC_LW, cpu_pkg::AC_SW: f = cpu_pkg::FN_ADD;
			cpu_pkg::AC_ANDI:  f = cpu_pkg::FN_AND;
			cpu_pkg::AC_ORI:   f = cpu_pkg::FN_OR;
			cpu_pkg::AC_SLTI:  f = cpu_pkg::FN_SLT;
			cpu_pkg::AC_SLTIU: f = cpu_pkg::FN_SLTU;
			cpu_pkg::AC_LUI:   return {y[15:0], 16'h0};
			cpu_pkg::AC_BEQ:   return (x == y) ? 32'd0 : 32'd1;
			cpu_pkg::AC_BNE:   return (x == y) ? 32'd1 : 32'd0;
			default:           return '0;
		endcase
		case (f)
			cpu_pkg::FN_ADD:   return x + y;
			cpu_pkg::FN_SUB:   return x - y;
			cpu_pkg::FN_AND:   return x & y;
			cpu_pkg::FN_OR:    return x | y;
			cpu_pkg::FN_NOR:   return ~(x | y);
			cpu_pkg::FN_SLT:   return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
			cpu_pkg::FN_SLTU:  return (x < y) ? 32'd1 : 32'd0;
			cpu_pkg::FN_SLL:   return y << sh;
			cpu_pkg::FN_SRL:   return y >> sh;
			cpu_pkg::FN_SLLV:  return x << y[4:0]; // counts kept below 32
			cpu_pkg::FN_SRLV:  return x >> y[4:0];
			cpu_pkg::FN_MULLO: return p[31:0];
			cpu_pkg::FN_MULHI: return p[63:32];
			default:           return '0;
		endcase
	endfunction

	task automatic check_word(string name, cpu_pkg::word_t exp, cpu_pkg::word_t got);
		checks++;
		if (exp !== got) begin
			errors++;
			$display("FAIL t=%0t %s exp %h got %h", $time, name, exp, got);
		end
	endtask

	// commit happens at the edge where the register file takes the write
	always @(posedge clk) begin
		if (arst_n && !stall && wb_rfw) begin
			if (q_addr.size() == 0) begin
				errors++;
				$display("t=%0t register write to r%0d that no instruction should make",
					$time, wb_waddr);
			end else begin
				check_word("wb_waddr", 32'(q_addr.pop_front()), 32'(wb_waddr));
				check_word("wb_wdata", q_data.pop_front(), wb_wdata);
				check_word("commit cycle", 32'(q_cyc.pop_front()), 32'(cyc));
			end
		end
		cyc++;
	end

	// **************************************************
	// instruction issue
	task automatic set_nop();
		id_c_rfw        = 1'b0;
		id_c_wbsource   = cpu_pkg::WB_ALU;
		id_c_drw        = '0;
		id_c_alucontrol = cpu_pkg::AC_RTYPE;
		id_func         = cpu_pkg::FN_SLL;
		id_c_j          = 1'b0;
		id_c_b          = 1'b0;
		id_c_jjr        = 1'b0;
		id_c_rfbse      = 1'b0;
		id_se           = '0;
		id_shamt        = '0;
		id_pc           = pc;
		id_jaddr        = '0;
		id_rs           = '0;
		id_rt           = '0;
		id_rf_waddr     = '0;
		flush           = 1'b0;
	endtask

	task automatic step();
		@(negedge clk);
		pc = pc + 32'd4;
		set_nop();
	endtask

	task automatic issue(cpu_pkg::func_t ac, cpu_pkg::func_t fn, cpu_pkg::reg_addr_t rs,
			cpu_pkg::reg_addr_t rt, cpu_pkg::reg_addr_t rd, cpu_pkg::word_t se,
			cpu_pkg::shamt_t sh, logic rfbse, logic rfw, cpu_pkg::wb_src_t src,
			cpu_pkg::drw_t drw);
		cpu_pkg::word_t y;
		cpu_pkg::word_t r;
		cpu_pkg::word_t v;
		y = rfbse ? se : shadow[rt];
		r = exp_alu(ac, fn, sh, shadow[rs], y);
		if (src == cpu_pkg::WB_MEM) v = mem_m[r[9:2]];
		else if (src == cpu_pkg::WB_LINK) v = pc + 32'd8;
		else v = r;
		id_c_alucontrol = ac;
		id_func         = fn;
		id_rs           = rs;
		id_rt           = rt;
		id_rf_waddr     = rd;
		id_se           = se;
		id_shamt        = sh;
		id_c_rfbse      = rfbse;
		id_c_rfw        = rfw;
		id_c_wbsource   = src;
		id_c_drw        = drw;
		id_pc           = pc;
		if (!flush) begin // flushed ones leave the model alone
			if (drw[0]) mem_m[r[9:2]] = shadow[rt];
			if (rfw) begin
				q_addr.push_back(rd);
				q_data.push_back(v);
				q_cyc.push_back(cyc + 2);
				if (rd != '0) shadow[rd] = v;
			end
		end
	endtask

	task automatic rtype(cpu_pkg::func_t fn, cpu_pkg::reg_addr_t rd, cpu_pkg::reg_addr_t rs,
			cpu_pkg::reg_addr_t rt, cpu_pkg::shamt_t sh);
		issue(cpu_pkg::AC_RTYPE, fn, rs, rt, rd, '0, sh, 1'b0, 1'b1, cpu_pkg::WB_ALU, 2'b00);
		step();
	endtask

	task automatic itype(cpu_pkg::func_t ac, cpu_pkg::reg_addr_t rt, cpu_pkg::reg_addr_t rs,
			cpu_pkg::word_t imm);
		issue(ac, '0, rs, rt, rt, imm, '0, 1'b1, 1'b1, cpu_pkg::WB_ALU, 2'b00);
		step();
	endtask

	task automatic load_word(cpu_pkg::reg_addr_t rd, cpu_pkg::word_t val);
		itype(cpu_pkg::AC_LUI, rd, 5'd0, sext16({16'h0, val[31:16]}));
		itype(cpu_pkg::AC_ORI, rd, rd, {16'h0, val[15:0]});
	endtask

	task automatic lw(cpu_pkg::reg_addr_t rt, cpu_pkg::word_t addr);
		issue(cpu_pkg::AC_LW, '0, 5'd0, rt, rt, addr, '0, 1'b1, 1'b1, cpu_pkg::WB_MEM, 2'b10);
		step();
	endtask

	task automatic sw(cpu_pkg::reg_addr_t rt, cpu_pkg::word_t addr);
		issue(cpu_pkg::AC_SW, '0, 5'd0, rt, 5'd0, addr, '0, 1'b1, 1'b0, cpu_pkg::WB_ALU, 2'b01);
		step();
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (q_addr.size() != 0 && n < 10) begin
			@(negedge clk);
			n++;
		end
		if (q_addr.size() != 0) begin
			errors++;
			$display("t=%0t timed out waiting for %0d writebacks", $time, q_addr.size());
			q_addr.delete();
			q_data.delete();
			q_cyc.delete();
		end
	endtask

	task automatic stall_for(int k);
		stall = 1'b1;
		foreach (q_cyc[i]) q_cyc[i] = q_cyc[i] + k; // in flight ones slip by k
		repeat (k) @(negedge clk);
		stall = 1'b0;
	endtask

	// **************************************************
	// directed tests
	task automatic test_arith();
		load_word(5'd1, rnd(32));
		load_word(5'd2, rnd(32));
		itype(cpu_pkg::AC_ADDI, 5'd3, 5'd0, sext16(rnd(16)));
		rtype(cpu_pkg::FN_ADD, 5'd4, 5'd1, 5'd2, '0);
		rtype(cpu_pkg::FN_SUB, 5'd4, 5'd1, 5'd2, '0);
		rtype(cpu_pkg::FN_AND, 5'd4, 5'd1, 5'd2, '0);
		rtype(cpu_pkg::FN_OR, 5'd4, 5'd1, 5'd2, '0);
		rtype(cpu_pkg::FN_NOR, 5'd4, 5'd1, 5'd2, '0);
		rtype(cpu_pkg::FN_SLL, 5'd4, 5'd0, 5'd1, 5'(rnd(5)));
		rtype(cpu_pkg::FN_SRL, 5'd4, 5'd0, 5'd1, 5'(rnd(5)));
		itype(cpu_pkg::AC_ADDI, 5'd10, 5'd0, rnd(5)); // small shift count
		rtype(cpu_pkg::FN_SLLV, 5'd4, 5'd1, 5'd10, '0);
		rtype(cpu_pkg::FN_SRLV, 5'd4, 5'd1, 5'd10, '0);
		itype(cpu_pkg::AC_LUI, 5'd4, 5'd0, sext16(rnd(16)));
		rtype(cpu_pkg::FN_SLT, 5'd4, 5'd1, 5'd2, '0);
		rtype(cpu_pkg::FN_SLTU, 5'd4, 5'd1, 5'd2, '0);
		itype(cpu_pkg::AC_SLTI, 5'd4, 5'd1, sext16(rnd(16)));
		itype(cpu_pkg::AC_SLTIU, 5'd4, 5'd1, sext16(rnd(16)));
		rtype(cpu_pkg::FN_MULLO, 5'd4, 5'd1, 5'd2, '0);
		rtype(cpu_pkg::FN_MULHI, 5'd4, 5'd1, 5'd2, '0);
		rtype(cpu_pkg::FN_ADD, 5'd0, 5'd1, 5'd2, '0); // r0 write
		rtype(cpu_pkg::FN_ADD, 5'd11, 5'd0, 5'd2, '0);
		drain();
	endtask

	task automatic test_forward();
		rtype(cpu_pkg::FN_ADD, 5'd5, 5'd1, 5'd2, '0);
		rtype(cpu_pkg::FN_SUB, 5'd6, 5'd5, 5'd1, '0);  // rs distance 1
		rtype(cpu_pkg::FN_ADD, 5'd7, 5'd1, 5'd5, '0);  // rt distance 2
		rtype(cpu_pkg::FN_AND, 5'd12, 5'd6, 5'd5, '0); // distance 2 and 3
		itype(cpu_pkg::AC_ADDI, 5'd14, 5'd0, sext16(rnd(16)));
		rtype(cpu_pkg::FN_SUB, 5'd15, 5'd1, 5'd14, '0);
		itype(cpu_pkg::AC_ADDI, 5'd9, 5'd0, 32'd1);
		itype(cpu_pkg::AC_ADDI, 5'd9, 5'd0, 32'd2);
		rtype(cpu_pkg::FN_ADD, 5'd13, 5'd9, 5'd9, '0); // newest r9 must win
		drain();
	endtask

	task automatic branch(cpu_pkg::func_t ac, cpu_pkg::reg_addr_t rs, cpu_pkg::reg_addr_t rt);
		cpu_pkg::word_t se;
		logic           taken;
		se     = sext16(rnd(16));
		taken  = (ac == cpu_pkg::AC_BEQ) ? (shadow[rs] == shadow[rt]) :
			(shadow[rs] != shadow[rt]);
		id_c_b = 1'b1;
		issue(ac, '0, rs, rt, 5'd0, se, '0, 1'b0, 1'b0, cpu_pkg::WB_ALU, 2'b00);
		#1;
		check_word("c_b", {31'b0, taken}, {31'b0, c_b});
		check_word("c_j", 32'd0, {31'b0, c_j});
		check_word("baddr", pc + 32'd4 + (se << 2), baddr);
		step();
	endtask

	task automatic test_branch();
		cpu_pkg::jidx_t idx;
		load_word(5'd16, rnd(32));
		rtype(cpu_pkg::FN_ADD, 5'd17, 5'd16, 5'd0, '0);
		branch(cpu_pkg::AC_BEQ, 5'd16, 5'd17);
		branch(cpu_pkg::AC_BNE, 5'd16, 5'd17);
		load_word(5'd18, rnd(32));
		branch(cpu_pkg::AC_BEQ, 5'd16, 5'd18);
		branch(cpu_pkg::AC_BNE, 5'd18, 5'd16);
		pc       = rnd(30) << 2;
		idx      = 26'(rnd(26));
		id_c_j   = 1'b1;
		id_jaddr = idx;
		issue(cpu_pkg::AC_RTYPE, cpu_pkg::FN_SLL, '0, '0, '0, '0, '0, 1'b0, 1'b0,
			cpu_pkg::WB_ALU, 2'b00);
		#1;
		check_word("c_j", 32'd1, {31'b0, c_j});
		check_word("jaddr", {pc[31:28] + 4'(pc[27:0] > 28'hffffffb), idx, 2'b00}, jaddr);
		step();
		rtype(cpu_pkg::FN_OR, 5'd19, 5'd16, 5'd18, '0);
		id_c_j   = 1'b1;
		id_c_jjr = 1'b1;
		issue(cpu_pkg::AC_RTYPE, cpu_pkg::FN_SLL, 5'd19, '0, '0, '0, '0, 1'b0, 1'b0,
			cpu_pkg::WB_ALU, 2'b00);
		#1;
		check_word("jaddr", shadow[19], jaddr); // jr takes forwarded rs
		step();
		id_c_j = 1'b1;
		issue(cpu_pkg::AC_RTYPE, cpu_pkg::FN_SLL, '0, '0, 5'd31, '0, '0, 1'b0, 1'b1,
			cpu_pkg::WB_LINK, 2'b00);
		step();
		step(); // link value only reaches the distance 2 path
		rtype(cpu_pkg::FN_ADD, 5'd16, 5'd31, 5'd0, '0);
		drain();
	endtask

	task automatic test_memory();
		cpu_pkg::word_t addr[4];
		for (int i = 0; i < 4; i++) begin
			addr[i] = rnd(8) << 2;
			load_word(5'd20, rnd(32));
			sw(5'd20, addr[i]); // store data forwarded from ori
		end
		step();
		step();
		for (int i = 0; i < 4; i++) begin
			lw(5'(21 + i), addr[i]);
		end
		drain();
	endtask

	task automatic test_stall_flush();
		cpu_pkg::word_t a;
		rtype(cpu_pkg::FN_ADD, 5'd9, 5'd1, 5'd2, '0);
		stall_for(4);
		drain();
		flush = 1'b1;
		itype(cpu_pkg::AC_ADDI, 5'd23, 5'd0, 32'd5); // flushed, no writeback
		rtype(cpu_pkg::FN_ADD, 5'd24, 5'd23, 5'd0, '0);
		drain();
		a = rnd(8) << 2;
		load_word(5'd25, rnd(32));
		sw(5'd25, a);
		load_word(5'd26, rnd(32));
		flush = 1'b1;
		sw(5'd26, a);
		step();
		step();
		lw(5'd27, a); // still the first store
		drain();
	endtask

	initial begin
		pc     = 32'h0040_0000;
		lfsr   = 32'd45742;
		cyc    = 0;
		errors = 0;
		checks = 0;
		stall  = 1'b0;
		arst_n = 1'b0;
		set_nop();
		foreach (shadow[i]) shadow[i] = '0;
		repeat (5) @(negedge clk);
		arst_n = 1'b1;
		test_arith();
		test_forward();
		test_branch();
		test_memory();
		test_stall_flush();
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
hw/cpu_pkg.sv
hw/ex_mem_if.sv
hw/cpu_rf.sv
hw/cpu_alu.sv
hw/cpu_ex.sv
hw/cpu_mem.sv
hw/cpu_backend.sv
bench/cpu_backend_props.sv
bench/tb_cpu_backend.sv

/* run.sh */
#!/bin/sh
# build and run the back end testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_backend \
	-f flist.f -o sim_tb || { echo "build error"; exit 1; }
./obj_dir/sim_tb | tee /dev/stderr | grep -q "TESTS PASSED" && exit 0 || exit 1
